/* tft_bus_pkg.sv */
package tft_bus_pkg;

    localparam int BUS_AW = 4;  // byte address, word registers
    localparam int BUS_DW = 32;

    typedef logic [BUS_DW-1:0] bus_data_t;
    typedef logic [BUS_AW-1:0] bus_addr_t;

    // register map
    localparam bus_addr_t REG_CMD    = 4'h0;  // write only, pushes a command word
    localparam bus_addr_t REG_STATUS = 4'h4;
    localparam bus_addr_t REG_RDATA  = 4'h8;  // read pops one captured byte

    // status bits
    localparam int ST_CMD_FULL = 0;
    localparam int ST_BUSY     = 1;
    localparam int ST_RD_VALID = 2;

endpackage

/* tft_spi_pkg.sv */
package tft_spi_pkg;

    localparam int FRAME_W = 16;
    localparam int DELAY_W = 16;

    // low half goes out on the wire, high half is the cs_n-high gap after it
    typedef struct packed {
        logic [DELAY_W-1:0] delay;
        logic [FRAME_W-1:0] frame;
    } spi_cmd_t;

    localparam logic [7:0] READ_OPCODE = 8'h40;

    typedef logic [7:0] rd_byte_t;

    function automatic logic is_read(logic [FRAME_W-1:0] frame);
        return frame[FRAME_W-1 -: 8] == READ_OPCODE;
    endfunction

endpackage

/* tft_cmd_if.sv */
`timescale 1ns/1ps

interface tft_cmd_if ();
    import tft_spi_pkg::*;

    logic     valid;  // head of command FIFO is valid
    spi_cmd_t cmd;
    logic     pop;    // one-cycle pulse from the shifter
    logic     busy;

    modport fifo_side (
        output valid,
        output cmd,
        input  pop
    );

    modport engine_side (
        input  valid,
        input  cmd,
        output pop,
        output busy
    );

    modport monitor (
        input busy
    );

endinterface

/* tft_sync_fifo.sv */
`timescale 1ns/1ps

module tft_sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic nrst,
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,
    output logic empty,
    output logic full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    // wrap explicitly, DEPTH need not be a power of two
    function automatic logic [AW-1:0] next_ptr(logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign do_push = push && !full;   // push into a full FIFO is lost
    assign do_pop  = pop && !empty;
    assign rdata   = mem[rd_ptr];     // head visible without read delay

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

endmodule

/* tft_mmio_regs.sv */
`timescale 1ns/1ps

module tft_mmio_regs (
    input  logic                              clk,
    input  logic                              nrst,
    input  logic [tft_bus_pkg::BUS_AW-1:0]    addr,
    input  logic                              wen,
    input  logic                              ren,
    input  tft_bus_pkg::bus_data_t            wdata,
    output tft_bus_pkg::bus_data_t            rdata,

    // command FIFO
    output logic                              cmd_push,
    output tft_spi_pkg::spi_cmd_t             cmd_data,
    input  logic                              cmd_full,

    // read byte FIFO
    output logic                              rd_pop,
    input  tft_spi_pkg::rd_byte_t             rd_byte,
    input  logic                              rd_empty,

    tft_cmd_if.monitor                        cmd_mon
);
    import tft_bus_pkg::*;
    import tft_spi_pkg::*;

    logic      sel_cmd;
    logic      sel_status;
    logic      sel_rdata;
    bus_data_t status;

    assign sel_cmd    = (addr == REG_CMD);
    assign sel_status = (addr == REG_STATUS);
    assign sel_rdata  = (addr == REG_RDATA);

    // write to a full command FIFO is dropped here
    assign cmd_push = wen && sel_cmd && !cmd_full;
    assign cmd_data = spi_cmd_t'(wdata);

    // no pop on an empty read FIFO
    assign rd_pop = ren && sel_rdata && !rd_empty;

    always_comb begin
        status              = '0;
        status[ST_CMD_FULL] = cmd_full;
        status[ST_BUSY]     = cmd_mon.busy;
        status[ST_RD_VALID] = !rd_empty;
    end

    // rdata valid the cycle after ren, held until the next read
    always_ff @(posedge clk) begin
        if (!nrst) begin
            rdata <= '0;
        end else if (ren) begin
            if (sel_status)
                rdata <= status;
            else if (sel_rdata && !rd_empty)
                rdata <= bus_data_t'(rd_byte);  // zero extended
            else
                rdata <= '0;
        end
    end

endmodule

/* tft_spi_shifter.sv */
`timescale 1ns/1ps

module tft_spi_shifter #(
    parameter int SCLK_HALF = 2
) (
    input  logic                  clk,
    input  logic                  nrst,
    tft_cmd_if.engine_side        cmd,

    output logic                  rd_push,
    output tft_spi_pkg::rd_byte_t rd_data,
    input  logic                  rd_full,

    // to the TFT controller
    output logic                  cs_n,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso
);
    import tft_spi_pkg::*;

    localparam int HW = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
    localparam int BW = $clog2(FRAME_W);
    localparam int RB = $bits(rd_byte_t);

    typedef enum logic [1:0] {IDLE, SHIFT, DELAY} state_t;

    state_t             state;
    logic [HW-1:0]      half_cnt;
    logic [BW-1:0]      bit_cnt;
    logic [DELAY_W-1:0] dly_cnt;
    logic               rd_frame;   // current frame is a read
    logic [FRAME_W-1:0] tx_sh;
    logic [FRAME_W-1:0] rx_sh;
    logic               blocked;
    logic               start;
    logic               half_done;
    logic               sclk_rise;
    logic               sclk_fall;
    logic               last_fall;

    // a read frame waits for room in the read FIFO; a byte pushed this
    // cycle is not yet counted in rd_full
    assign blocked   = is_read(cmd.cmd.frame) && (rd_full || rd_push);
    assign start     = (state == IDLE) && cmd.valid && !blocked;
    assign cmd.pop   = start;
    assign cmd.busy  = (state != IDLE);

    assign half_done = (half_cnt == HW'(SCLK_HALF - 1));
    assign sclk_rise = (state == SHIFT) && half_done && !sclk;
    assign sclk_fall = (state == SHIFT) && half_done && sclk;
    assign last_fall = sclk_fall && (bit_cnt == BW'(FRAME_W - 1));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state    <= IDLE;
            cs_n     <= 1'b1;
            sclk     <= 1'b0;
            mosi     <= 1'b0;
            rd_push  <= 1'b0;
            rd_frame <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            dly_cnt  <= '0;
        end else begin
            rd_push <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= SHIFT;
                        cs_n     <= 1'b0;
                        mosi     <= cmd.cmd.frame[FRAME_W-1];  // msb valid at cs_n fall
                        rd_frame <= is_read(cmd.cmd.frame);
                        dly_cnt  <= cmd.cmd.delay;
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end
                SHIFT: begin
                    half_cnt <= half_done ? '0 : half_cnt + 1'b1;
                    if (half_done)
                        sclk <= ~sclk;
                    if (last_fall) begin
                        cs_n    <= 1'b1;
                        mosi    <= 1'b0;
                        rd_push <= rd_frame;
                        // gap of 0 or 1 both give one idle cycle
                        if (dly_cnt > DELAY_W'(1)) begin
                            state   <= DELAY;
                            dly_cnt <= dly_cnt - DELAY_W'(2);
                        end else begin
                            state <= IDLE;
                        end
                    end else if (sclk_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        mosi    <= tx_sh[FRAME_W-1];
                    end
                end
                DELAY: begin
                    if (dly_cnt == '0)
                        state <= IDLE;
                    else
                        dly_cnt <= dly_cnt - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            tx_sh <= cmd.cmd.frame << 1;  // bit 15 already on mosi
        else if (sclk_fall)
            tx_sh <= tx_sh << 1;
        if (sclk_rise)
            rx_sh <= {rx_sh[FRAME_W-2:0], miso};
        if (last_fall)
            rd_data <= rx_sh[RB-1:0];
    end

endmodule

/* tft_display_top.sv */
`timescale 1ns/1ps

module tft_display_top #(
    parameter int CMD_DEPTH = 4,
    parameter int RD_DEPTH  = 4,
    parameter int SCLK_HALF = 2
) (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic [tft_bus_pkg::BUS_AW-1:0] addr,
    input  logic                           wen,
    input  logic                           ren,
    input  tft_bus_pkg::bus_data_t         wdata,
    output tft_bus_pkg::bus_data_t         rdata,

    output logic                           cs_n,
    output logic                           sclk,
    output logic                           mosi,
    input  logic                           miso
);
    import tft_spi_pkg::*;

    spi_cmd_t cmd_wdata;
    logic     cmd_push;
    logic     cmd_full;
    logic     cmd_empty;
    rd_byte_t rd_wdata;
    rd_byte_t rd_head;
    logic     rd_push;
    logic     rd_pop;
    logic     rd_empty;
    logic     rd_full;

    tft_cmd_if cmd_bus ();

    assign cmd_bus.valid = ~cmd_empty;

    // command words, head goes straight to the shifter
    tft_sync_fifo #(
        .T     (spi_cmd_t),
        .DEPTH (CMD_DEPTH)
    ) u_cmd_fifo (
        .clk   (clk),
        .nrst  (nrst),
        .push  (cmd_push),
        .wdata (cmd_wdata),
        .pop   (cmd_bus.pop),
        .rdata (cmd_bus.cmd),
        .empty (cmd_empty),
        .full  (cmd_full)
    );

    tft_sync_fifo #(
        .T     (rd_byte_t),
        .DEPTH (RD_DEPTH)
    ) u_rd_fifo (
        .clk   (clk),
        .nrst  (nrst),
        .push  (rd_push),
        .wdata (rd_wdata),
        .pop   (rd_pop),
        .rdata (rd_head),
        .empty (rd_empty),
        .full  (rd_full)
    );

    tft_mmio_regs u_regs (
        .clk      (clk),
        .nrst     (nrst),
        .addr     (addr),
        .wen      (wen),
        .ren      (ren),
        .wdata    (wdata),
        .rdata    (rdata),
        .cmd_push (cmd_push),
        .cmd_data (cmd_wdata),
        .cmd_full (cmd_full),
        .rd_pop   (rd_pop),
        .rd_byte  (rd_head),
        .rd_empty (rd_empty),
        .cmd_mon  (cmd_bus)
    );

    tft_spi_shifter #(
        .SCLK_HALF (SCLK_HALF)
    ) u_shifter (
        .clk     (clk),
        .nrst    (nrst),
        .cmd     (cmd_bus),
        .rd_push (rd_push),
        .rd_data (rd_wdata),
        .rd_full (rd_full),
        .cs_n    (cs_n),
        .sclk    (sclk),
        .mosi    (mosi),
        .miso    (miso)
    );

endmodule

/* tb_tft_checker.sv */
`timescale 1ns/1ps

module tb_tft_checker (
    input  logic        clk,
    input  logic        nrst,
    input  logic        cs_n,
    input  logic        sclk,
    input  logic        mosi,
    input  logic [3:0]  addr,
    input  logic        ren,
    input  logic [31:0] rdata,
    input  logic [31:0] st_mask,
    input  logic [31:0] st_exp,
    input  logic        expect_idle,  // no frame may start while high
    output int          frame_cnt,
    output int          pass_cnt,
    output int          fail_cnt
);
    import tft_bus_pkg::*;

    logic [127:0] k_name  [0:31];
    logic [15:0]  k_frame [0:31];
    logic [15:0]  k_delay [0:31];
    int           k_gap   [0:31];
    logic [7:0]   rd_exp  [0:31];
    logic [127:0] rd_name [0:31];
    int           n_kept;
    int           n_reads;
    int           rd_ptr;
    logic         cs_q;
    logic         sclk_q;
    logic         init_chk;
    logic         rd_chk;
    logic         st_chk;
    logic [31:0]  mask_q;
    logic [31:0]  exp_q;
    logic [15:0]  rx;
    int           rises;
    int           gap_cnt;

    task automatic report(input logic [127:0] name, input string what, input logic ok,
                          input logic [31:0] exp, input logic [31:0] act);
        if (ok) begin
            pass_cnt++;
            $display("PASS %0s %0s", name, what);
        end else begin
            fail_cnt++;
            $display("FAIL %0s %0s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic error(input string msg);
        fail_cnt++;
        $display("ERROR %0s", msg);
    endtask

    initial begin
        int           fd;
        int           n;
        int           batch;
        int           keep;
        int           gap;
        string        line;
        logic [127:0] nm;
        logic [15:0]  frame;
        logic [15:0]  delay;
        logic [15:0]  resp;
        logic [7:0]   exp;
        n_kept    = 0;
        n_reads   = 0;
        rd_ptr    = 0;
        frame_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        fd = $fopen("tft_trace.txt", "r");
        if (fd == 0)
            error("checker cannot open tft_trace.txt");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%s %d %d %d %h %h %h %h", nm, batch, keep, gap,
                        frame, delay, resp, exp);
            if (n != 8 || keep == 0)
                continue;  // dropped writes never reach the wire
            k_name[n_kept]  = nm;
            k_frame[n_kept] = frame;
            k_delay[n_kept] = delay;
            k_gap[n_kept]   = gap;
            if (frame[15:8] == 8'h40) begin
                rd_exp[n_reads]  = exp;
                rd_name[n_reads] = nm;
                n_reads++;
            end
            n_kept++;
        end
        if (fd != 0)
            $fclose(fd);
    end

    always @(posedge clk) begin
        if (!nrst) begin
            cs_q     = 1'b1;
            sclk_q   = 1'b0;
            init_chk = 1'b1;
            rd_chk   = 1'b0;
            st_chk   = 1'b0;
            gap_cnt  = 0;
        end else begin
            if (init_chk)
                report("reset", "pins", cs_n && !sclk, 32'h2, {30'b0, cs_n, sclk});
            init_chk = 1'b0;

            if (!cs_n && cs_q) begin  // frame start
                if (expect_idle)
                    error("a frame started while the read FIFO was full");
                if (frame_cnt > 0 && frame_cnt < n_kept && k_gap[frame_cnt] != 0)
                    report(k_name[frame_cnt], "gap",
                           gap_cnt == ((k_delay[frame_cnt-1] == 0) ? 1 : k_delay[frame_cnt-1]),
                           (k_delay[frame_cnt-1] == 0) ? 1 : k_delay[frame_cnt-1], gap_cnt);
                rx    = '0;
                rises = 0;
            end
            if (!cs_n && sclk && !sclk_q) begin
                rx = {rx[14:0], mosi};
                rises++;
            end
            if (cs_n && !cs_q) begin  // frame end
                if (frame_cnt >= n_kept) begin
                    error($sformatf("unexpected frame %h on mosi", rx));
                end else begin
                    report(k_name[frame_cnt], "frame", rx == k_frame[frame_cnt],
                           k_frame[frame_cnt], rx);
                    report(k_name[frame_cnt], "edges", rises == 16, 16, rises);
                end
                frame_cnt++;
                gap_cnt = 0;
            end
            if (cs_n)
                gap_cnt++;

            if (rd_chk) begin
                if (rd_ptr >= n_reads)
                    error("read byte popped with none expected");
                else
                    report(rd_name[rd_ptr], "rdata", rdata == {24'b0, rd_exp[rd_ptr]},
                           {24'b0, rd_exp[rd_ptr]}, rdata);
                rd_ptr++;
            end
            if (st_chk)
                report("status", "bits", (rdata & mask_q) == exp_q, exp_q, rdata & mask_q);
            rd_chk = ren && (addr == REG_RDATA);
            st_chk = ren && (addr == REG_STATUS);
            mask_q = st_mask;
            exp_q  = st_exp;
            cs_q   = cs_n;
            sclk_q = sclk;
        end
    end

endmodule

/* tb_tft_top.sv */
`timescale 1ns/1ps

module tb_tft_top;
    import tft_bus_pkg::*;

    localparam int RD_DEPTH = 4;
    localparam int TMO      = 2000;  // cycles per wait

    logic        clk = 1'b0;
    logic        nrst;
    logic [3:0]  addr;
    logic        wen;
    logic        ren;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        cs_n;
    logic        sclk;
    logic        mosi;
    logic        miso;
    logic [31:0] st_mask;
    logic [31:0] st_exp;
    logic        expect_idle;
    int          frame_cnt;
    int          pass_cnt;
    int          fail_cnt;

    int          t_batch [0:31];
    int          t_keep  [0:31];
    logic [15:0] t_frame [0:31];
    logic [15:0] t_delay [0:31];
    logic [15:0] k_resp  [0:31];  // slave response per frame on the wire
    int          n_lines;
    int          s_frame;
    int          s_bit;
    logic [15:0] s_word;
    logic        s_cs_q;
    logic        s_sclk_q;

    always #5 clk = ~clk;

    tft_display_top #(
        .CMD_DEPTH (4),
        .RD_DEPTH  (RD_DEPTH),
        .SCLK_HALF (2)
    ) dut0 (
        .clk   (clk),
        .nrst  (nrst),
        .addr  (addr),
        .wen   (wen),
        .ren   (ren),
        .wdata (wdata),
        .rdata (rdata),
        .cs_n  (cs_n),
        .sclk  (sclk),
        .mosi  (mosi),
        .miso  (miso)
    );

    tb_tft_checker u_chk (
        .clk         (clk),
        .nrst        (nrst),
        .cs_n        (cs_n),
        .sclk        (sclk),
        .mosi        (mosi),
        .addr        (addr),
        .ren         (ren),
        .rdata       (rdata),
        .st_mask     (st_mask),
        .st_exp      (st_exp),
        .expect_idle (expect_idle),
        .frame_cnt   (frame_cnt),
        .pass_cnt    (pass_cnt),
        .fail_cnt    (fail_cnt)
    );

    // mode 0 slave puts the msb out at cs_n fall and the next bit on each sclk fall
    always @(negedge clk) begin
        if (!cs_n && s_cs_q) begin
            s_word = k_resp[s_frame];
            s_frame++;
            miso  = s_word[15];
            s_bit = 14;
        end else if (!cs_n && !sclk && s_sclk_q && s_bit >= 0) begin
            miso = s_word[s_bit];
            s_bit--;
        end
        s_cs_q   = cs_n;
        s_sclk_q = sclk;
    end

    task automatic abort(input string msg);
        $display("ERROR %0s", msg);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic load_trace();
        int           fd;
        int           n;
        int           gap;
        int           kept;
        string        line;
        logic [127:0] nm;
        logic [15:0]  resp;
        logic [7:0]   exp;
        n_lines = 0;
        kept    = 0;
        fd = $fopen("tft_trace.txt", "r");
        if (fd == 0) begin
            abort("cannot open tft_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %d %d %d %h %h %h %h", nm, t_batch[n_lines],
                            t_keep[n_lines], gap, t_frame[n_lines], t_delay[n_lines],
                            resp, exp);
                if (n != 8)
                    continue;
                if (t_keep[n_lines] != 0) begin
                    k_resp[kept] = resp;
                    kept++;
                end
                n_lines++;
            end
            $fclose(fd);
        end
    endtask

    task automatic bus_write(input logic [31:0] data);
        @(negedge clk);
        addr  = REG_CMD;
        wen   = 1'b1;
        wdata = data;
    endtask

    task automatic bus_idle();
        @(negedge clk);
        wen = 1'b0;
        ren = 1'b0;
    endtask

    // mask and expected value held until the checker has compared
    task automatic bus_read(input logic [3:0] a, input logic [31:0] mask,
                            input logic [31:0] exp);
        @(negedge clk);
        addr    = a;
        ren     = 1'b1;
        st_mask = mask;
        st_exp  = exp;
        @(negedge clk);
        ren = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_frames(input int target);
        int t;
        t = 0;
        while (frame_cnt < target) begin
            @(negedge clk);
            t++;
            if (t > TMO)
                abort($sformatf("timed out waiting for frame %0d to finish", target));
        end
    endtask

    initial begin
        int   line;
        int   first;
        int   b;
        int   kept;
        int   pending;
        logic drop;
        logic is_rd;
        addr        = '0;
        wen         = 1'b0;
        ren         = 1'b0;
        wdata       = '0;
        miso        = 1'b0;
        nrst        = 1'b0;
        st_mask     = '0;
        st_exp      = '0;
        expect_idle = 1'b0;
        s_frame     = 0;
        s_bit       = -1;
        s_cs_q      = 1'b1;
        s_sclk_q    = 1'b0;
        load_trace();
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        bus_read(REG_STATUS, '1, '0);  // reset state

        line    = 0;
        kept    = 0;
        pending = 0;
        while (line < n_lines) begin
            b     = t_batch[line];
            first = line;
            drop  = 1'b0;
            while (line < n_lines && t_batch[line] == b) begin
                bus_write({t_delay[line], t_frame[line]});
                if (t_keep[line] == 0)
                    drop = 1'b1;
                line++;
            end
            bus_idle();
            if (drop)  // first frame of the batch still shifting
                bus_read(REG_STATUS, (32'h1 << ST_CMD_FULL) | (32'h1 << ST_BUSY),
                         (32'h1 << ST_CMD_FULL) | (32'h1 << ST_BUSY));
            for (int i = first; i < line; i++) begin
                if (t_keep[i] == 0)
                    continue;
                is_rd = (t_frame[i][15:8] == 8'h40);
                if (is_rd && pending == RD_DEPTH) begin
                    expect_idle = 1'b1;
                    repeat (100) @(negedge clk);  // frame must stay parked
                    bus_read(REG_STATUS, 32'h6, 32'h1 << ST_RD_VALID);
                    expect_idle = 1'b0;
                    bus_read(REG_RDATA, '0, '0);
                    pending--;
                end
                wait_frames(kept + 1);
                kept++;
                if (is_rd)
                    pending++;
            end
            if (pending > 0)
                bus_read(REG_STATUS, 32'h1 << ST_RD_VALID, 32'h1 << ST_RD_VALID);
            while (pending > 0) begin
                bus_read(REG_RDATA, '0, '0);
                pending--;
            end
            bus_read(REG_STATUS, 32'h1 << ST_RD_VALID, '0);  // nothing left behind
        end

        @(negedge clk);
        $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* tft_trace.txt */
# name batch keep gap frame delay slave_resp exp_byte (numbers after gap in hex)
# same batch is written back to back, keep 0 is a write dropped on a full FIFO
wr_single 1 1 0 2a5c 0003 0000 00
rd_single 2 1 0 40a7 0004 c35e 5e
gap_d5 3 1 0 8011 0005 0000 00
gap_d0 3 1 1 8122 0000 0000 00
gap_d1 3 1 1 8233 0001 0000 00
gap_d9 3 1 1 8455 0009 0000 00
gap_end 3 1 1 8566 0000 0000 00
fill_0 4 1 0 9101 0003 0000 00
fill_1 4 1 1 9202 0003 0000 00
fill_2 4 1 1 9303 0002 0000 00
fill_3 4 1 1 9404 0004 0000 00
fill_4 4 1 1 9505 0003 0000 00
fill_drop 4 0 0 9f0f 0003 0000 00
rdq_0 5 1 0 4011 0002 a1b2 b2
rdq_1 5 1 1 4022 0003 17c4 c4
rdq_2 5 1 1 4033 0002 5e09 09
rdq_3 5 1 1 4044 0002 e67d 7d
rdq_4 5 1 0 4055 0002 3390 90

/* files.f */
tft_bus_pkg.sv
tft_spi_pkg.sv
tft_cmd_if.sv
tft_sync_fifo.sv
tft_mmio_regs.sv
tft_spi_shifter.sv
tft_display_top.sv
tb_tft_checker.sv
tb_tft_top.sv

/* Makefile */
.PHONY: all run lint clean

all: run

run:
	verilator --binary -f files.f --top-module tb_tft_top -o tb_sim
	./obj_dir/tb_sim 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -f files.f --top-module tft_display_top

clean:
	rm -rf obj_dir sim.log
